// File: include/serdes_rx_consts.svh
// SERDES receive constants

`ifndef SERDES_RX_CONSTS_SVH
`define SERDES_RX_CONSTS_SVH

// K codes, all with K flag set on the lane
`define SERDES_K_COMMA        8'hBC   // K28.5
`define SERDES_K_IDLE         8'h3C   // K28.1
`define SERDES_K_START        8'hDC   // K28.6
`define SERDES_K_END          8'h9C   // K28.4
`define SERDES_K_XON          8'h5C   // K28.2
`define SERDES_K_XOFF         8'h7C   // K28.3

// Data byte sent after the comma
`define SERDES_D_56           8'hC5   // D5.6

// Result buffer sizing
`define SERDES_RX_DEPTH       16
`define SERDES_RX_MAX_CREDIT  8

// CRC-16-CCITT start value
`define SERDES_CRC_SEED       16'hFFFF

`endif

// File: src/serdes_rx_pkg.sv
// SERDES receive types

`default_nettype none

package serdes_rx_pkg;

   // Class of one aligned byte pair
   typedef enum logic [2:0] {
      SYM_DATA  = 3'd0,   // Both lanes data
      SYM_START = 3'd1,
      SYM_END   = 3'd2,
      SYM_HOLD  = 3'd3,   // Comma/D5.6, XON or XOFF pair
      SYM_BAD   = 3'd4
   } sym_kind_e;

   typedef enum logic [2:0] {
      FRM_IDLE  = 3'd0,
      FRM_HALF1 = 3'd1,   // Waiting for low half-word
      FRM_HALF2 = 3'd2,   // Waiting for high half-word
      FRM_CRC   = 3'd3,
      FRM_ERROR = 3'd4,
      FRM_DONE  = 3'd5
   } frm_state_e;

   // One buffer entry, 35 bits
   typedef struct packed {
      logic        error;
      logic        sop;
      logic        eop;
      logic [31:0] data;
   } rx_entry_t;

endpackage

`default_nettype wire

// File: src/serdes_sym_if.sv
// SERDES aligned symbol link

`default_nettype none

interface serdes_sym_if
   import serdes_rx_pkg::*;
   ();

   logic        sym_valid;   // Alignment known
   sym_kind_e   kind;
   logic [15:0] half;        // First received byte in [7:0]
   logic        lock_odd;    // Alignment in use

   modport dec (
      output sym_valid,
      output kind,
      output half,
      output lock_odd
   );

   modport frm (
      input  sym_valid,
      input  kind,
      input  half,
      input  lock_odd
   );

endinterface

`default_nettype wire

// File: src/serdes_sym_decode.sv
// SERDES symbol alignment and decode

`default_nettype none
`include "serdes_rx_consts.svh"

module serdes_sym_decode
   import serdes_rx_pkg::*;
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic [15:0] ser_r_i,
   input  logic        ser_rklsb_i,
   input  logic        ser_rkmsb_i,
   serdes_sym_if.dec   sym,
   output logic        xon_rcvd_o,
   output logic        xoff_rcvd_o
);

   // Pairs are {k_hi, k_lo, hi, lo}, lo received first
   localparam logic [17:0] START_PAIR = {2'b11, `SERDES_K_START, `SERDES_K_START};
   localparam logic [17:0] END_PAIR   = {2'b11, `SERDES_K_END, `SERDES_K_END};
   localparam logic [17:0] COMMA_PAIR = {2'b01, `SERDES_D_56, `SERDES_K_COMMA};
   localparam logic [17:0] XON_PAIR   = {2'b11, `SERDES_K_XON, `SERDES_K_XON};
   localparam logic [17:0] XOFF_PAIR  = {2'b11, `SERDES_K_XOFF, `SERDES_K_XOFF};

   logic [8:0]  held_q;   // Previous high byte with its K flag
   logic [17:0] even_pair;
   logic [17:0] odd_pair;
   logic [17:0] pick;
   logic        even_start;
   logic        odd_start;
   logic        lock_n;
   sym_kind_e   kind_n;
   logic        xon_hit;
   logic        xon_hit_q;
   logic        xoff_hit;
   logic        xoff_hit_q;

   assign even_pair  = {ser_rkmsb_i, ser_rklsb_i, ser_r_i};
   assign odd_pair   = {ser_rklsb_i, held_q[8], ser_r_i[7:0], held_q[7:0]};
   assign even_start = (even_pair == START_PAIR);
   assign odd_start  = (odd_pair == START_PAIR);

   // A start pair picks the alignment, even wins a tie
   assign lock_n = even_start ? 1'b0 : (odd_start ? 1'b1 : sym.lock_odd);
   assign pick   = lock_n ? odd_pair : even_pair;

   always_comb
   begin
      if (pick[17:16] == 2'b00)
         kind_n = SYM_DATA;
      else if (pick == START_PAIR)
         kind_n = SYM_START;
      else if (pick == END_PAIR)
         kind_n = SYM_END;
      else if (pick == COMMA_PAIR || pick == XON_PAIR || pick == XOFF_PAIR)
         kind_n = SYM_HOLD;   // Far side is flow controlled
      else
         kind_n = SYM_BAD;
   end

   // Any lane, so either alignment is seen
   assign xon_hit  = (ser_rkmsb_i && ser_r_i[15:8] == `SERDES_K_XON) ||
                     (ser_rklsb_i && ser_r_i[7:0] == `SERDES_K_XON);
   assign xoff_hit = (ser_rkmsb_i && ser_r_i[15:8] == `SERDES_K_XOFF) ||
                     (ser_rklsb_i && ser_r_i[7:0] == `SERDES_K_XOFF);

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         held_q        <= '0;
         sym.sym_valid <= 1'b0;
         sym.lock_odd  <= 1'b0;
         xon_hit_q     <= 1'b0;
         xoff_hit_q    <= 1'b0;
         xon_rcvd_o    <= 1'b0;
         xoff_rcvd_o   <= 1'b0;
      end
      else
      begin
         held_q        <= {ser_rkmsb_i, ser_r_i[15:8]};
         sym.sym_valid <= sym.sym_valid | even_start | odd_start;
         sym.lock_odd  <= lock_n;
         xon_hit_q     <= xon_hit;
         xoff_hit_q    <= xoff_hit;
         xon_rcvd_o    <= xon_hit & ~xon_hit_q;   // One pulse per code run
         xoff_rcvd_o   <= xoff_hit & ~xoff_hit_q;
      end
   end

   always_ff @(posedge ser_rx_clk)
   begin
      sym.kind <= kind_n;
      sym.half <= pick[15:0];
   end

endmodule

`default_nettype wire

// File: src/serdes_pkt_framer.sv
// SERDES packet framer with CRC-16 check

`default_nettype none
`include "serdes_rx_consts.svh"

module serdes_pkt_framer
   import serdes_rx_pkg::*;
(
   input  logic      ser_rx_clk,
   input  logic      rst_rxclk,
   serdes_sym_if.frm sym,
   input  logic      buf_full_i,
   output logic      ent_wr_o,
   output rx_entry_t ent_o
);

   localparam logic [15:0] CRC_POLY = 16'h1021;   // CCITT

   frm_state_e  state;
   frm_state_e  state_n;
   sym_kind_e   kind;
   logic        pkt_start;
   logic        crc_ok;
   logic        wr_n;
   logic        sop_pend;   // Next line is the first of the packet
   logic [15:0] half_lo;
   logic [15:0] crc;
   rx_entry_t   ent_n;

   // Sixteen bits, MSB first
   function automatic logic [15:0] crc16_step(input logic [15:0] crc_in,
                                              input logic [15:0] d);
      logic [15:0] c;
      logic        fb;
      c = crc_in;
      for (int i = 15; i >= 0; i--)
      begin
         fb = c[15] ^ d[i];
         c  = {c[14:0], 1'b0} ^ (fb ? CRC_POLY : 16'h0000);
      end
      return c;
   endfunction

   // Before alignment nothing is acted on
   assign kind      = sym.sym_valid ? sym.kind : SYM_HOLD;
   assign pkt_start = (state == FRM_IDLE || state == FRM_DONE) && kind == SYM_START;
   assign crc_ok    = (kind == SYM_DATA) && (sym.half == crc);

   always_comb
   begin
      state_n = state;
      wr_n    = 1'b0;
      case (state)
         FRM_IDLE, FRM_DONE:
            state_n = pkt_start ? FRM_HALF1 : FRM_IDLE;
         FRM_HALF1:
            if (kind == SYM_DATA)
               state_n = FRM_HALF2;
            else if (kind == SYM_END)
               state_n = FRM_CRC;   // Between lines
            else if (kind != SYM_HOLD)
               state_n = FRM_ERROR;
         FRM_HALF2:
            if (kind == SYM_DATA && !buf_full_i)
            begin
               state_n = FRM_HALF1;
               wr_n    = 1'b1;
            end
            else if (kind != SYM_HOLD)
               state_n = FRM_ERROR;   // Odd count, bad code or overflow
         FRM_CRC:
            if (crc_ok && !buf_full_i)
            begin
               state_n = FRM_DONE;
               wr_n    = 1'b1;
            end
            else if (kind != SYM_HOLD)
               state_n = FRM_ERROR;
         FRM_ERROR:
            if (!buf_full_i)
            begin
               state_n = FRM_IDLE;
               wr_n    = 1'b1;
            end
         default:
            state_n = FRM_IDLE;
      endcase
   end

   always_comb
   begin
      ent_n       = '0;
      ent_n.error = (state == FRM_ERROR);
      ent_n.eop   = (state == FRM_CRC);
      ent_n.sop   = sop_pend && (state == FRM_HALF2);
      if (state == FRM_HALF2)
         ent_n.data = {sym.half, half_lo};
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         state    <= FRM_IDLE;
         ent_wr_o <= 1'b0;
         sop_pend <= 1'b0;
      end
      else
      begin
         state    <= state_n;
         ent_wr_o <= wr_n;
         if (pkt_start)
            sop_pend <= 1'b1;
         else if (wr_n)
            sop_pend <= 1'b0;
      end
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (wr_n)
         ent_o <= ent_n;
      if (pkt_start)
         crc <= `SERDES_CRC_SEED;
      else if (kind == SYM_DATA && (state == FRM_HALF1 || state == FRM_HALF2))
         crc <= crc16_step(crc, sym.half);
      if (state == FRM_HALF1 && kind == SYM_DATA)
         half_lo <= sym.half;   // Low half of the line
   end

endmodule

`default_nettype wire

// File: src/serdes_rx_buffer.sv
// SERDES receive result buffer

`default_nettype none
`include "serdes_rx_consts.svh"

module serdes_rx_buffer
   import serdes_rx_pkg::*;
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic        ent_wr_i,
   input  rx_entry_t   ent_i,
   output logic        buf_full_o,
   input  logic        wr_credit_i,
   output logic        wr_valid_o,
   output logic [31:0] wr_dat_o,
   output logic        wr_sop_o,
   output logic        wr_eop_o,
   output logic        wr_error_o,
   output logic [4:0]  fifo_occupied_o
);

   localparam int AW = $clog2(`SERDES_RX_DEPTH);
   localparam int CW = $clog2(`SERDES_RX_MAX_CREDIT + 1);

   rx_entry_t     mem [`SERDES_RX_DEPTH];
   rx_entry_t     head;
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic [CW-1:0] credits;
   logic          push;
   logic          pop;

   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      return (p == AW'(`SERDES_RX_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign buf_full_o = (count == (AW + 1)'(`SERDES_RX_DEPTH));
   assign push       = ent_wr_i && !buf_full_o;
   assign pop        = (credits != '0) && (count != '0);   // Present only with credit

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // Credit pulse and pop together cancel
   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         credits <= '0;
      else if (wr_credit_i && !pop)
      begin
         if (credits != CW'(`SERDES_RX_MAX_CREDIT))
            credits <= credits + 1'b1;   // Saturates at the limit
      end
      else if (pop && !wr_credit_i)
         credits <= credits - 1'b1;
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (push)
         mem[wr_ptr] <= ent_i;
   end

   assign head            = mem[rd_ptr];
   assign wr_valid_o      = pop;
   assign wr_dat_o        = head.data;
   assign wr_sop_o        = head.sop;
   assign wr_eop_o        = head.eop;
   assign wr_error_o      = head.error;
   assign fifo_occupied_o = count;

endmodule

`default_nettype wire

// File: src/serdes_rx_top.sv
// SERDES receive path top level

`default_nettype none

module serdes_rx_top
   import serdes_rx_pkg::*;
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic [15:0] ser_r_i,
   input  logic        ser_rklsb_i,
   input  logic        ser_rkmsb_i,
   input  logic        wr_credit_i,
   output logic        wr_valid_o,
   output logic [31:0] wr_dat_o,
   output logic        wr_sop_o,
   output logic        wr_eop_o,
   output logic        wr_error_o,
   output logic        xon_rcvd_o,
   output logic        xoff_rcvd_o,
   output logic [4:0]  fifo_occupied_o
);

   logic      ent_wr;
   rx_entry_t ent;
   logic      buf_full;

   serdes_sym_if sym_if ();

   serdes_sym_decode u_decode (
      .ser_rx_clk  (ser_rx_clk),
      .rst_rxclk   (rst_rxclk),
      .ser_r_i     (ser_r_i),
      .ser_rklsb_i (ser_rklsb_i),
      .ser_rkmsb_i (ser_rkmsb_i),
      .sym         (sym_if.dec),
      .xon_rcvd_o  (xon_rcvd_o),
      .xoff_rcvd_o (xoff_rcvd_o)
   );

   serdes_pkt_framer u_framer (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .sym        (sym_if.frm),
      .buf_full_i (buf_full),
      .ent_wr_o   (ent_wr),
      .ent_o      (ent)
   );

   serdes_rx_buffer u_buffer (
      .ser_rx_clk      (ser_rx_clk),
      .rst_rxclk       (rst_rxclk),
      .ent_wr_i        (ent_wr),
      .ent_i           (ent),
      .buf_full_o      (buf_full),
      .wr_credit_i     (wr_credit_i),
      .wr_valid_o      (wr_valid_o),
      .wr_dat_o        (wr_dat_o),
      .wr_sop_o        (wr_sop_o),
      .wr_eop_o        (wr_eop_o),
      .wr_error_o      (wr_error_o),
      .fifo_occupied_o (fifo_occupied_o)
   );

endmodule

`default_nettype wire

// File: tests/serdes_rx_checker.sv
// Result buffer protocol assertions

`default_nettype none
`include "serdes_rx_consts.svh"

module serdes_rx_checker (
   input logic                                         ser_rx_clk,
   input logic                                         rst_rxclk,
   input logic                                         ent_wr_i,
   input logic                                         buf_full_i,
   input logic                                         credit_i,
   input logic                                         valid_i,
   input logic [$clog2(`SERDES_RX_MAX_CREDIT + 1)-1:0] credits_i,
   input logic [$clog2(`SERDES_RX_DEPTH):0]            count_i
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CW = $clog2(`SERDES_RX_MAX_CREDIT + 1);
   localparam int AW = $clog2(`SERDES_RX_DEPTH);

   logic [CW-1:0] held_credits;   // Granted by the pulses and not yet spent

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         held_credits <= '0;
      else if (credit_i && !valid_i && held_credits != CW'(`SERDES_RX_MAX_CREDIT))
         held_credits <= held_credits + 1'b1;
      else if (valid_i && !credit_i)
         held_credits <= held_credits - 1'b1;
   end

   // Framer must hold off while the buffer is full
   a_no_write_full: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      !(ent_wr_i && buf_full_i))
      else $error("Entry written while buffer full");

   a_valid_credit: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      !(valid_i && held_credits == '0))
      else $error("Output valid with no credit granted");

   a_credit_max: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      credits_i <= CW'(`SERDES_RX_MAX_CREDIT))
      else $error("Credit count above limit");

   a_occupancy_max: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      count_i <= (AW + 1)'(`SERDES_RX_DEPTH))   // Occupancy bound
      else $error("Buffer occupancy above depth");

endmodule

bind serdes_rx_buffer serdes_rx_checker u_checker (
   .ser_rx_clk (ser_rx_clk),
   .rst_rxclk  (rst_rxclk),
   .ent_wr_i   (ent_wr_i),
   .buf_full_i (buf_full_o),
   .credit_i   (wr_credit_i),
   .valid_i    (wr_valid_o),
   .credits_i  (credits),
   .count_i    (count)
);

`default_nettype wire

// File: tests/serdes_rx_tb.sv
// SERDES receive path testbench

`default_nettype none
`include "serdes_rx_consts.svh"

module serdes_rx_tb
   import serdes_rx_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int         TIMEOUT_CYCLES = 4000;   // Six tests of well under 200 cycles
   localparam logic [8:0] IDLE_B = {1'b1, `SERDES_K_IDLE};

   logic        ser_rx_clk;
   logic        rst_rxclk;
   logic [15:0] ser_r_i;
   logic        ser_rklsb_i;
   logic        ser_rkmsb_i;
   logic        wr_credit_i;
   logic        wr_valid_o;
   logic [31:0] wr_dat_o;
   logic        wr_sop_o;
   logic        wr_eop_o;
   logic        wr_error_o;
   logic        xon_rcvd_o;
   logic        xoff_rcvd_o;
   logic [4:0]  fifo_occupied_o;

   logic [8:0]  link_q[$];   // {k, byte} in wire order
   logic [15:0] pkt[$];      // Payload half-words
   rx_entry_t   got_q[$];
   rx_entry_t   exp_q[$];
   int          push_cnt;
   int          credit_req;
   bit          credit_auto;
   int          xon_cnt;
   int          xoff_cnt;
   int          cycles;
   int          errors;
   bit          ended;

   serdes_rx_top DUT (.*);

   always #5 ser_rx_clk = ~ser_rx_clk;

   // Link model sends two bytes per clock and idle pairs when starved
   always @(posedge ser_rx_clk)
   begin
      logic [8:0] lo;
      logic [8:0] hi;
      #1;
      lo = IDLE_B;
      hi = IDLE_B;
      if (link_q.size() >= 2)
      begin
         lo = link_q.pop_front();
         hi = link_q.pop_front();
      end
      {ser_rklsb_i, ser_r_i[7:0]}  = lo;
      {ser_rkmsb_i, ser_r_i[15:8]} = hi;
   end

   always @(posedge ser_rx_clk)
   begin
      #1;
      if (credit_req > 0)
      begin
         wr_credit_i = 1'b1;
         credit_req  = credit_req - 1;
      end
      else
         wr_credit_i = credit_auto;
   end

   // Collector samples at the falling edge where outputs are settled
   always @(negedge ser_rx_clk)
   begin
      if (!rst_rxclk)
      begin
         if (wr_valid_o)
            got_q.push_back(rx_entry_t'({wr_error_o, wr_sop_o, wr_eop_o, wr_dat_o}));
         if (xon_rcvd_o)
            xon_cnt = xon_cnt + 1;
         if (xoff_rcvd_o)
            xoff_cnt = xoff_cnt + 1;
      end
   end

   always @(posedge ser_rx_clk)
   begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         ended = 1'b1;
         $display("Test failed");
         $fatal(1, "Timeout, expected DUT output missing after %0d cycles", TIMEOUT_CYCLES);
      end
   end

   task automatic report_error(input string msg);
      errors = errors + 1;
      ended  = 1'b1;
      $display("** Error at time %0t: %s", $time, msg);
      $display("Test failed");
      $fatal(1, "Stopped at the first mismatch");
   endtask

   task automatic check_entry(input rx_entry_t got, input rx_entry_t exp, input int idx);
      if (got !== exp)
         report_error($sformatf(
            "entry %0d is %b/%b/%b/%h, expected %b/%b/%b/%h (err/sop/eop/data)",
            idx, got.error, got.sop, got.eop, got.data,
            exp.error, exp.sop, exp.eop, exp.data));
   endtask

   task automatic check_flag(input int got, input int exp, input string what);
      if (got != exp)
         report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
   endtask

   function automatic rx_entry_t mk_entry(input logic err, input logic sop, input logic eop,
                                          input logic [31:0] d);
      rx_entry_t e;
      e.error = err;
      e.sop   = sop;
      e.eop   = eop;
      e.data  = d;
      return e;
   endfunction

   // CRC-16-CCITT taking the high byte of the half-word first
   function automatic logic [15:0] crc_model(input logic [15:0] crc_in, input logic [15:0] h);
      logic [15:0] c;
      c = crc_in;
      for (int n = 1; n >= 0; n--)
      begin
         c = c ^ {h[n*8 +: 8], 8'h00};
         for (int k = 0; k < 8; k++)
            c = c[15] ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
      end
      return c;
   endfunction

   task automatic put_pair(input logic [8:0] lo, input logic [8:0] hi);
      link_q.push_back(lo);
      link_q.push_back(hi);
      push_cnt = push_cnt + 2;
   endtask

   task automatic put_kk(input logic [7:0] b);
      put_pair({1'b1, b}, {1'b1, b});
   endtask

   task automatic put_half(input logic [15:0] h);
      put_pair({1'b0, h[7:0]}, {1'b0, h[15:8]});   // Low byte goes first
   endtask

   // One stray idle byte moves the stream by half a word
   task automatic set_align(input bit odd);
      if ((push_cnt % 2) != int'(odd))
      begin
         link_q.push_back(IDLE_B);
         push_cnt = push_cnt + 1;
      end
   endtask

   task automatic put_hold(input int mode, input bit second);
      if (mode == 1)
         put_pair({1'b1, `SERDES_K_COMMA}, {1'b0, `SERDES_D_56});
      else if (second)
         put_kk(`SERDES_K_XOFF);
      else
         put_kk(`SERDES_K_XON);
   endtask

   task automatic make_payload(input int lines);
      pkt.delete();
      for (int i = 0; i < 2 * lines; i++)
         pkt.push_back(16'($urandom()));
   endtask

   // Mode 0 no holds, 1 comma pairs, 2 XON and XOFF pairs
   task automatic send_packet(input bit odd, input int hold_mode, input bit bad_crc);
      logic [15:0] crc;
      int          n;
      int          at_a;
      int          at_b;
      n    = pkt.size();
      at_a = $urandom % n;
      at_b = $urandom % n;
      crc  = `SERDES_CRC_SEED;
      set_align(odd);
      put_kk(`SERDES_K_START);
      for (int i = 0; i < n; i++)
      begin
         if (hold_mode != 0 && i == at_a)
            put_hold(hold_mode, 1'b0);
         if (hold_mode != 0 && i == at_b)
            put_hold(hold_mode, 1'b1);
         put_half(pkt[i]);
         crc = crc_model(crc, pkt[i]);
      end
      put_kk(`SERDES_K_END);
      if (hold_mode == 1)
         put_hold(1, 1'b0);   // Freeze while the CRC is due
      put_half(bad_crc ? crc ^ 16'h0001 : crc);
      put_kk(`SERDES_K_IDLE);
      put_kk(`SERDES_K_IDLE);
      for (int i = 0; i < n / 2; i++)
         exp_q.push_back(mk_entry(1'b0, i == 0, 1'b0, {pkt[2*i+1], pkt[2*i]}));
      exp_q.push_back(mk_entry(bad_crc, 1'b0, !bad_crc, 32'h0));
   endtask

   task automatic check_results();
      while (got_q.size() < exp_q.size())
         @(negedge ser_rx_clk);
      repeat (8) @(negedge ser_rx_clk);   // Room for any stray entry
      check_flag(got_q.size(), exp_q.size(), "Output entry count");
      foreach (exp_q[i])
         check_entry(got_q[i], exp_q[i], i);
      check_flag(fifo_occupied_o, 0, "Occupancy after draining");
      got_q.delete();
      exp_q.delete();
   endtask

   task automatic test_credit_hold();
      make_payload(4);
      send_packet(1'b0, 0, 1'b0);
      while (fifo_occupied_o != 5'd5)
         @(negedge ser_rx_clk);
      check_flag(got_q.size(), 0, "Entries released without credit");
      credit_req = 3;
      while (got_q.size() < 3)
         @(negedge ser_rx_clk);
      repeat (8) @(negedge ser_rx_clk);
      check_flag(got_q.size(), 3, "Entries released by three credits");
      check_flag(fifo_occupied_o, 2, "Occupancy after three credits");
      credit_auto = 1'b1;
      check_results();
   endtask

   task automatic test_framing_errors();
      logic [15:0] crc;
      make_payload(2);
      crc = crc_model(crc_model(crc_model(`SERDES_CRC_SEED, pkt[0]), pkt[1]), pkt[2]);
      set_align(1'b0);
      put_kk(`SERDES_K_START);
      for (int i = 0; i < 3; i++)
         put_half(pkt[i]);
      put_kk(`SERDES_K_END);   // Odd half-word count
      put_half(crc);
      put_kk(`SERDES_K_IDLE);
      exp_q.push_back(mk_entry(1'b0, 1'b1, 1'b0, {pkt[1], pkt[0]}));
      exp_q.push_back(mk_entry(1'b1, 1'b0, 1'b0, 32'h0));
      put_kk(`SERDES_K_START);
      put_half(pkt[2]);
      put_half(pkt[3]);
      put_pair({1'b1, `SERDES_K_START}, {1'b1, `SERDES_K_END});
      put_half(pkt[0]);
      put_kk(`SERDES_K_END);
      put_kk(`SERDES_K_IDLE);
      exp_q.push_back(mk_entry(1'b0, 1'b1, 1'b0, {pkt[3], pkt[2]}));
      exp_q.push_back(mk_entry(1'b1, 1'b0, 1'b0, 32'h0));
      check_results();
      make_payload(3);
      send_packet(1'b1, 0, 1'b0);
      check_results();
   endtask

   task automatic test_flow_codes();
      int xon0;
      int xoff0;
      check_flag(xon_cnt, 0, "XON pulses before flow code test");
      check_flag(xoff_cnt, 0, "XOFF pulses before flow code test");
      xon0  = xon_cnt;
      xoff0 = xoff_cnt;
      make_payload(4);
      send_packet(1'b0, 2, 1'b0);
      check_results();
      check_flag(xon_cnt - xon0, 1, "XON pulses");
      check_flag(xoff_cnt - xoff0, 1, "XOFF pulses");
   endtask

   initial
   begin
      void'($urandom(32'h646f));
      ser_rx_clk  = 1'b0;
      rst_rxclk   = 1'b1;
      ser_r_i     = {`SERDES_K_IDLE, `SERDES_K_IDLE};
      ser_rklsb_i = 1'b1;
      ser_rkmsb_i = 1'b1;
      wr_credit_i = 1'b0;
      credit_auto = 1'b0;
      credit_req  = 0;
      repeat (10) @(posedge ser_rx_clk);
      #1;
      rst_rxclk = 1'b0;
      test_credit_hold();   // Runs first while the credit count is still zero
      make_payload(4);
      send_packet(1'b0, 0, 1'b0);
      check_results();
      send_packet(1'b1, 1, 1'b0);   // Same payload at odd alignment with holds
      check_results();
      make_payload(4);
      send_packet(1'b0, 0, 1'b1);
      check_results();
      test_framing_errors();
      test_flow_codes();
      ended = 1'b1;
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // Reached when an assertion stops the run
   final
   begin
      if (!ended)
         $display("Test failed");
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
src/serdes_rx_pkg.sv
src/serdes_sym_if.sv
src/serdes_sym_decode.sv
src/serdes_pkt_framer.sv
src/serdes_rx_buffer.sv
src/serdes_rx_top.sv
tests/serdes_rx_checker.sv
tests/serdes_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SERDES receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module serdes_rx_tb \
   -f filelist.f -o serdes_rx_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/serdes_rx_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "Test completed successfully"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
